//--- verilog/spim_pkg.sv
////////////////////////////////////////
// shared types and register map for the spi master
// offsets are byte addresses on a 16-bit apb bus
////////////////////////////////////////
`default_nettype none

package spim_pkg;

  // one data word for apb, buffers and shifter
  typedef logic [31:0] word_t;

  ////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////
  localparam logic [15:0] ADDR_CMD         = 16'h0000;
  // write only, pushes wbuf
  localparam logic [15:0] ADDR_TXDATA      = 16'h0008;
  localparam logic [15:0] ADDR_STATUS      = 16'h000C;
  localparam logic [15:0] ADDR_DIAG0       = 16'h0010;
  localparam logic [15:0] ADDR_DIAG1       = 16'h0014;
  // read pops rbuf
  localparam logic [15:0] ADDR_RXDATA      = 16'h0018;
  localparam logic [15:0] ADDR_WBUF_RDBACK = 16'h0020;
  // reserved window, reads zero
  localparam logic [15:0] ADDR_RSVD0       = 16'h0030;
  localparam logic [15:0] ADDR_RSVD1       = 16'h0034;
  localparam logic [15:0] ADDR_RSVD2       = 16'h0038;
  localparam logic [15:0] ADDR_RSVD3       = 16'h003C;
  localparam logic [15:0] ADDR_WBUF_STAT   = 16'h0040;
  localparam logic [15:0] ADDR_WBUF_CTRL   = 16'h0044;
  localparam logic [15:0] ADDR_RBUF_STAT   = 16'h0048;
  localparam logic [15:0] ADDR_RBUF_CTRL   = 16'h004C;

  ////////////////////////////////////////
  // command fields
  ////////////////////////////////////////
  localparam int CMD_GO        = 0;
  localparam int CMD_COUNT_LSB = 8;
  localparam int CMD_COUNT_MSB = 15;
  // one-hot chip select request
  localparam int CMD_CS_LSB    = 30;
  localparam int CMD_CS_MSB    = 31;

  // buffer control bits, active while set
  localparam int CTRL_CLR_OVF = 0;
  localparam int CTRL_CLR_UDF = 1;
  localparam int CTRL_FLUSH   = 2;

  // buffer status bits
  localparam int STAT_UDF = 0;
  localparam int STAT_OVF = 1;

  localparam word_t UNMAPPED_RDATA = 32'hdead_beef;

endpackage

`default_nettype wire

//--- verilog/spim_buf_if.sv
////////////////////////////////////////
// buffer port bundle, control lines are
// driven only by the register block side
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface spim_buf_if #(
  parameter int FIFO_AW = 3
);
  // write side
  logic                push;
  spim_pkg::word_t     push_data;
  // read side, head valid while not empty
  logic                pop;
  spim_pkg::word_t     pop_data;
  // occupancy
  logic                full;
  logic                empty;
  logic [FIFO_AW:0]    level;
  // sticky error flags and their controls
  logic                ovf_sticky;
  logic                udf_sticky;
  logic                clr_ovf;
  logic                clr_udf;
  logic                flush;

  modport writer (
    output push, push_data, clr_ovf, clr_udf, flush,
    input  pop_data, full, empty, level, ovf_sticky, udf_sticky
  );

  modport reader (
    output pop, clr_ovf, clr_udf, flush,
    input  pop_data, full, empty, level, ovf_sticky, udf_sticky
  );

  modport fifo (
    input  push, push_data, pop, clr_ovf, clr_udf, flush,
    output pop_data, full, empty, level, ovf_sticky, udf_sticky
  );

endinterface

`default_nettype wire

//--- verilog/spim_fifo.sv
////////////////////////////////////////
// push when full is dropped, pop when empty is ignored
// flush and sticky clears act while held high
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spim_fifo #(
  parameter int FIFO_AW = 3
) (
  input  logic       aclk,
  input  logic       arst_n,
  spim_buf_if.fifo   bus
);

  localparam int DEPTH = 1 << FIFO_AW;

  spim_pkg::word_t      mem [DEPTH];
  logic [FIFO_AW-1:0]   wr_ptr;
  logic [FIFO_AW-1:0]   rd_ptr;
  logic [FIFO_AW:0]     cnt_q;
  logic                 full_w;
  logic                 empty_w;
  logic                 do_push;
  logic                 do_pop;
  logic                 ovf_q;
  logic                 udf_q;

  // flags from the registered level
  assign full_w  = (cnt_q == (FIFO_AW+1)'(DEPTH));
  assign empty_w = (cnt_q == '0);

  // flush takes priority over traffic
  assign do_push = bus.push && !full_w && !bus.flush;
  assign do_pop  = bus.pop && !empty_w && !bus.flush;

  assign bus.full       = full_w;
  assign bus.empty      = empty_w;
  assign bus.level      = cnt_q;
  assign bus.pop_data   = mem[rd_ptr];
  assign bus.ovf_sticky = ovf_q;
  assign bus.udf_sticky = udf_q;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= bus.push_data;
    end
  end

  ////////////////////////////////////////
  // pointers and level
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end else if (bus.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end else begin
      // pointers wrap on their own width
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // sticky error flags
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ovf_q <= 1'b0;
      udf_q <= 1'b0;
    end else begin
      // clear held high wins over a new event
      if (bus.clr_ovf) begin
        ovf_q <= 1'b0;
      end else if (bus.push && full_w) begin
        ovf_q <= 1'b1;
      end
      if (bus.clr_udf) begin
        udf_q <= 1'b0;
      end else if (bus.pop && empty_w) begin
        udf_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/spim_csr.sv
////////////////////////////////////////
// apb slave, no wait states, pready tied high
// captured registers lag their sources by one cycle
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spim_csr (
  input  logic             aclk,
  input  logic             arst_n,
  // apb slave
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [15:0]      paddr,
  input  spim_pkg::word_t  pwdata,
  output spim_pkg::word_t  prdata,
  output logic             pready,
  output logic             pslverr,
  // engine handshake
  input  logic             busy,
  input  logic             word_done,
  input  spim_pkg::word_t  rx_word,
  input  logic             xfer_done,
  output logic             go,
  output logic [7:0]       count,
  output logic [1:0]       cs_sel,
  // buffers
  spim_buf_if.writer       wbuf,
  spim_buf_if.reader       rbuf
);

  logic            access;
  logic            wr_en;
  logic            rd_en;
  logic            mapped;
  spim_pkg::word_t cmd_q;
  spim_pkg::word_t status_q;
  spim_pkg::word_t diag0_q;
  spim_pkg::word_t diag1_q;
  spim_pkg::word_t rdback_q;
  spim_pkg::word_t wstat_q;
  spim_pkg::word_t wctrl_q;
  spim_pkg::word_t rstat_q;
  spim_pkg::word_t rctrl_q;

  ////////////////////////////////////////
  // access decode
  ////////////////////////////////////////
  // everything lands in the access phase
  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;
  assign pready = 1'b1;

  // buffer strobes
  assign wbuf.push      = wr_en && (paddr == spim_pkg::ADDR_TXDATA);
  assign wbuf.push_data = pwdata;
  assign rbuf.pop       = rd_en && (paddr == spim_pkg::ADDR_RXDATA);

  // soft controls straight from the ctrl registers
  assign wbuf.clr_ovf = wctrl_q[spim_pkg::CTRL_CLR_OVF];
  assign wbuf.clr_udf = wctrl_q[spim_pkg::CTRL_CLR_UDF];
  assign wbuf.flush   = wctrl_q[spim_pkg::CTRL_FLUSH];
  assign rbuf.clr_ovf = rctrl_q[spim_pkg::CTRL_CLR_OVF];
  assign rbuf.clr_udf = rctrl_q[spim_pkg::CTRL_CLR_UDF];
  assign rbuf.flush   = rctrl_q[spim_pkg::CTRL_FLUSH];

  // command fields to the engine
  assign go     = cmd_q[spim_pkg::CMD_GO];
  assign count  = cmd_q[spim_pkg::CMD_COUNT_MSB:spim_pkg::CMD_COUNT_LSB];
  assign cs_sel = cmd_q[spim_pkg::CMD_CS_MSB:spim_pkg::CMD_CS_LSB];

  ////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_q   <= '0;
      wctrl_q <= '0;
      rctrl_q <= '0;
    end else begin
      // end of transfer wins over a host write
      if (xfer_done) begin
        cmd_q[spim_pkg::CMD_GO] <= 1'b0;
      end else if (wr_en && (paddr == spim_pkg::ADDR_CMD)) begin
        cmd_q <= pwdata;
      end
      if (wr_en && (paddr == spim_pkg::ADDR_WBUF_CTRL)) begin
        wctrl_q <= pwdata;
      end
      if (wr_en && (paddr == spim_pkg::ADDR_RBUF_CTRL)) begin
        rctrl_q <= pwdata;
      end
    end
  end

  ////////////////////////////////////////
  // capture registers
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      status_q <= '0;
      diag0_q  <= '0;
      diag1_q  <= '0;
      rdback_q <= '0;
      wstat_q  <= '0;
      rstat_q  <= '0;
    end else begin
      status_q <= {31'b0, busy};
      // last received word
      if (word_done) begin
        diag0_q <= rx_word;
      end
      // rbuf level above wbuf level
      diag1_q  <= {16'b0, 8'(rbuf.level), 8'(wbuf.level)};
      rdback_q <= wbuf.empty ? '0 : wbuf.pop_data;
      wstat_q                     <= '0;
      wstat_q[spim_pkg::STAT_OVF] <= wbuf.ovf_sticky;
      wstat_q[spim_pkg::STAT_UDF] <= wbuf.udf_sticky;
      rstat_q                     <= '0;
      rstat_q[spim_pkg::STAT_OVF] <= rbuf.ovf_sticky;
      rstat_q[spim_pkg::STAT_UDF] <= rbuf.udf_sticky;
    end
  end

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////
  always_comb begin
    prdata = spim_pkg::UNMAPPED_RDATA;
    mapped = 1'b1;
    case (paddr)
      // reserved command bits read zero
      spim_pkg::ADDR_CMD:         prdata = {cmd_q[31:30], 14'b0, cmd_q[15:0]};
      spim_pkg::ADDR_TXDATA:      prdata = '0;
      spim_pkg::ADDR_STATUS:      prdata = status_q;
      spim_pkg::ADDR_DIAG0:       prdata = diag0_q;
      spim_pkg::ADDR_DIAG1:       prdata = diag1_q;
      // empty pop returns zero
      spim_pkg::ADDR_RXDATA:      prdata = rbuf.empty ? '0 : rbuf.pop_data;
      spim_pkg::ADDR_WBUF_RDBACK: prdata = rdback_q;
      spim_pkg::ADDR_RSVD0,
      spim_pkg::ADDR_RSVD1,
      spim_pkg::ADDR_RSVD2,
      spim_pkg::ADDR_RSVD3:       prdata = '0;
      spim_pkg::ADDR_WBUF_STAT:   prdata = wstat_q;
      spim_pkg::ADDR_WBUF_CTRL:   prdata = wctrl_q;
      spim_pkg::ADDR_RBUF_STAT:   prdata = rstat_q;
      spim_pkg::ADDR_RBUF_CTRL:   prdata = rctrl_q;
      default:                    mapped = 1'b0;
    endcase
  end

  // error only on a hole in the map
  assign pslverr = access && !mapped;

endmodule

`default_nettype wire

//--- verilog/spim_engine.sv
////////////////////////////////////////
// spi mode 0 only, 32-bit words msb first
// CLK_DIV must be even and at least 2
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spim_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic             aclk,
  input  logic             arst_n,
  // command from the register block
  input  logic             go,
  input  logic [7:0]       count,
  input  logic [1:0]       cs_sel,
  // spi pins
  input  logic             miso,
  output logic             sclk,
  output logic             mosi,
  output logic [1:0]       cs_n,
  // progress back to the register block
  output logic             busy,
  output logic             word_done,
  output spim_pkg::word_t  rx_word,
  output logic             xfer_done,
  // buffers
  spim_buf_if.reader       txq,
  spim_buf_if.writer       rxq
);

  localparam int HALF  = CLK_DIV / 2;
  localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_SHIFT,
    ST_FINISH
  } state_t;

  state_t          state;
  logic [7:0]      words_left;
  logic [DIV_W-1:0] div_cnt;
  logic [4:0]      bit_cnt;
  logic            sclk_q;
  logic            miso_q;
  logic            half_end;
  logic            can_pop;
  spim_pkg::word_t shreg;

  // end of one sclk half period
  assign half_end = (div_cnt == DIV_W'(HALF - 1));
  // back-pressure on both buffers
  assign can_pop  = (state == ST_LOAD) && (words_left != 8'd0) && !txq.empty && !rxq.full;

  assign txq.pop       = can_pop;
  assign rxq.push      = (state == ST_FINISH);
  assign rxq.push_data = shreg;

  assign word_done = (state == ST_FINISH);
  assign rx_word   = shreg;
  // nothing left, go back to idle
  assign xfer_done = (state == ST_LOAD) && (words_left == 8'd0);

  assign sclk = sclk_q;
  assign mosi = (state == ST_SHIFT) ? shreg[31] : 1'b0;
  assign cs_n = busy ? ~cs_sel : 2'b11;

  ////////////////////////////////////////
  // control fsm and divider
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      busy       <= 1'b0;
      words_left <= '0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      sclk_q     <= 1'b0;
      miso_q     <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (go) begin
            busy       <= 1'b1;
            words_left <= count;
            state      <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (words_left == 8'd0) begin
            busy  <= 1'b0;
            state <= ST_IDLE;
          end else if (can_pop) begin
            words_left <= words_left - 8'd1;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            state      <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (half_end) begin
            div_cnt <= '0;
            sclk_q  <= ~sclk_q;
            // rising edge samples, falling edge advances
            if (!sclk_q) begin
              miso_q <= miso;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
              if (bit_cnt == 5'd31) begin
                state <= ST_FINISH;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        // word pushed to rbuf this cycle
        default: state <= ST_LOAD;
      endcase
    end
  end

  ////////////////////////////////////////
  // shift register, tx out the top, rx in the bottom
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (can_pop) begin
      shreg <= txq.pop_data;
    end else if ((state == ST_SHIFT) && half_end && sclk_q) begin
      shreg <= {shreg[30:0], miso_q};
    end
  end

endmodule

`default_nettype wire

//--- verilog/spim_top.sv
////////////////////////////////////////
// apb spi master, single clock domain
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spim_top #(
  // log2 of each buffer depth
  parameter int FIFO_AW = 3,
  // aclk cycles per sclk period
  parameter int CLK_DIV = 4
) (
  input  logic             aclk,
  input  logic             arst_n,
  // apb slave
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [15:0]      paddr,
  input  spim_pkg::word_t  pwdata,
  output spim_pkg::word_t  prdata,
  output logic             pready,
  output logic             pslverr,
  // spi master
  output logic             sclk,
  output logic             mosi,
  output logic [1:0]       cs_n,
  input  logic             miso
);

  logic            go;
  logic [7:0]      count;
  logic [1:0]      cs_sel;
  logic            busy;
  logic            word_done;
  logic            xfer_done;
  spim_pkg::word_t rx_word;

  ////////////////////////////////////////
  // buffers
  ////////////////////////////////////////
  spim_buf_if #(.FIFO_AW(FIFO_AW)) wbuf_bus ();
  spim_buf_if #(.FIFO_AW(FIFO_AW)) rbuf_bus ();

  // host to engine
  spim_fifo #(.FIFO_AW(FIFO_AW)) u_wbuf (
    .aclk   (aclk),
    .arst_n (arst_n),
    .bus    (wbuf_bus.fifo)
  );

  // engine to host
  spim_fifo #(.FIFO_AW(FIFO_AW)) u_rbuf (
    .aclk   (aclk),
    .arst_n (arst_n),
    .bus    (rbuf_bus.fifo)
  );

  ////////////////////////////////////////
  // register block and engine
  ////////////////////////////////////////
  spim_csr u_csr (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .busy      (busy),
    .word_done (word_done),
    .rx_word   (rx_word),
    .xfer_done (xfer_done),
    .go        (go),
    .count     (count),
    .cs_sel    (cs_sel),
    .wbuf      (wbuf_bus.writer),
    .rbuf      (rbuf_bus.reader)
  );

  spim_engine #(.CLK_DIV(CLK_DIV)) u_engine (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .go        (go),
    .count     (count),
    .cs_sel    (cs_sel),
    .miso      (miso),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .busy      (busy),
    .word_done (word_done),
    .rx_word   (rx_word),
    .xfer_done (xfer_done),
    .txq       (wbuf_bus.reader),
    .rxq       (rbuf_bus.writer)
  );

endmodule

`default_nettype wire

//--- tb/spim_tb.sv
////////////////////////////////////////
// directed tests, default parameters only
// miso is looped back from mosi
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spim_tb;

  // two worst case transfers of 8 words x 32 bits x 4 clocks, a 400 cycle stall
  // and under a hundred 3-cycle accesses fit well below this
  localparam int MAX_CYCLES = 20000;

  logic            aclk;
  logic            arst_n;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [15:0]     paddr;
  spim_pkg::word_t pwdata;
  spim_pkg::word_t prdata;
  logic            pready;
  logic            pslverr;
  logic            sclk;
  logic            mosi;
  logic [1:0]      cs_n;
  logic            miso;

  int              errors;
  int              checks;
  int              cycles;
  spim_pkg::word_t rng_state;

  // loopback
  assign miso = mosi;

  spim_top uut (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .sclk    (sclk),
    .mosi    (mosi),
    .cs_n    (cs_n),
    .miso    (miso)
  );

  // 100 ns period
  always #50 aclk = ~aclk;

  ////////////////////////////////////////
  // run limit
  ////////////////////////////////////////
  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run passed %0d cycles without finishing", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // numerical recipes lcg
  function automatic spim_pkg::word_t lcg_next(input spim_pkg::word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic spim_pkg::word_t rand_word();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_word(input spim_pkg::word_t got, input spim_pkg::word_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // apb driver
  ////////////////////////////////////////
  task automatic apb_write(input logic [15:0] addr, input spim_pkg::word_t data);
    @(posedge aclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge aclk);
    penable <= 1'b1;
    // write lands on this edge
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [15:0] addr, output spim_pkg::word_t data,
                          output logic err);
    @(posedge aclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge aclk);
    penable <= 1'b1;
    // prdata settles mid access phase
    @(negedge aclk);
    data = prdata;
    err  = pslverr;
    // no wait states
    check_bit(pready, 1'b1, "pready");
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // read a mapped register and compare data and pslverr
  task automatic expect_reg(input logic [15:0] addr, input spim_pkg::word_t exp,
                            input spim_pkg::word_t mask, input string what);
    spim_pkg::word_t data;
    logic            err;
    apb_read(addr, data, err);
    check_word(data & mask, exp, what);
    check_bit(err, 1'b0, {what, " pslverr"});
  endtask

  // poll the status busy bit
  task automatic wait_busy(input logic level);
    spim_pkg::word_t st;
    logic            err;
    apb_read(spim_pkg::ADDR_STATUS, st, err);
    while (st[0] !== level) begin
      apb_read(spim_pkg::ADDR_STATUS, st, err);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_reset_decode();
    int              e0;
    spim_pkg::word_t data;
    logic            err;
    e0 = errors;
    expect_reg(spim_pkg::ADDR_CMD, '0, '1, "cmd");
    expect_reg(spim_pkg::ADDR_STATUS, '0, '1, "status");
    expect_reg(spim_pkg::ADDR_WBUF_CTRL, '0, '1, "wbuf ctrl");
    expect_reg(spim_pkg::ADDR_RBUF_CTRL, '0, '1, "rbuf ctrl");
    expect_reg(spim_pkg::ADDR_WBUF_STAT, '0, '1, "wbuf stat");
    expect_reg(spim_pkg::ADDR_RBUF_STAT, '0, '1, "rbuf stat");
    expect_reg(spim_pkg::ADDR_DIAG0, '0, '1, "diag0");
    expect_reg(spim_pkg::ADDR_DIAG1, '0, '1, "diag1");
    expect_reg(spim_pkg::ADDR_RSVD0, '0, '1, "rsvd0");
    expect_reg(spim_pkg::ADDR_RSVD1, '0, '1, "rsvd1");
    expect_reg(spim_pkg::ADDR_RSVD2, '0, '1, "rsvd2");
    expect_reg(spim_pkg::ADDR_RSVD3, '0, '1, "rsvd3");
    // hole in the map
    apb_read(16'h0004, data, err);
    check_word(data, 32'hdead_beef, "offset 0x04");
    check_bit(err, 1'b1, "offset 0x04 pslverr");
    check_bit(cs_n[0], 1'b1, "cs_n[0]");
    check_bit(cs_n[1], 1'b1, "cs_n[1]");
    // spi pins idle low
    check_bit(sclk, 1'b0, "sclk idle");
    check_bit(mosi, 1'b0, "mosi idle");
    report_test("reset_decode", e0);
  endtask

  task automatic test_cmd_mask();
    int e0;
    e0 = errors;
    // bits 29:16 read back as zero
    apb_write(spim_pkg::ADDR_CMD, 32'hffff_fffe);
    expect_reg(spim_pkg::ADDR_CMD, 32'hc000_fffe, '1, "cmd masked");
    report_test("cmd_mask", e0);
  endtask

  task automatic test_loopback();
    int              e0;
    spim_pkg::word_t words [5];
    spim_pkg::word_t cmd;
    e0 = errors;
    foreach (words[i]) begin
      words[i] = rand_word();
      apb_write(spim_pkg::ADDR_TXDATA, words[i]);
    end
    expect_reg(spim_pkg::ADDR_WBUF_RDBACK, words[0], '1, "wbuf readback");
    // cs 01, count 5, go
    cmd = {2'b01, 14'b0, 8'd5, 8'h01};
    apb_write(spim_pkg::ADDR_CMD, cmd);
    wait_busy(1'b1);
    @(negedge aclk);
    check_bit(cs_n[0], 1'b0, "cs_n[0] busy");
    check_bit(cs_n[1], 1'b1, "cs_n[1] busy");
    wait_busy(1'b0);
    expect_reg(spim_pkg::ADDR_CMD, cmd & ~32'h1, '1, "cmd after xfer");
    foreach (words[i]) begin
      expect_reg(spim_pkg::ADDR_RXDATA, words[i], '1, "rxdata");
    end
    expect_reg(spim_pkg::ADDR_DIAG0, words[4], '1, "diag0");
    report_test("loopback", e0);
  endtask

  task automatic test_wbuf_overflow();
    int e0;
    e0 = errors;
    // one more than the depth
    repeat (9) begin
      apb_write(spim_pkg::ADDR_TXDATA, rand_word());
    end
    expect_reg(spim_pkg::ADDR_WBUF_STAT, 32'd1 << spim_pkg::STAT_OVF, '1, "wbuf ovf");
    expect_reg(spim_pkg::ADDR_DIAG1, 32'd8, 32'hff, "wbuf level full");
    apb_write(spim_pkg::ADDR_WBUF_CTRL, 32'd1 << spim_pkg::CTRL_CLR_OVF);
    apb_write(spim_pkg::ADDR_WBUF_CTRL, '0);
    expect_reg(spim_pkg::ADDR_WBUF_STAT, '0, '1, "wbuf ovf cleared");
    apb_write(spim_pkg::ADDR_WBUF_CTRL, 32'd1 << spim_pkg::CTRL_FLUSH);
    apb_write(spim_pkg::ADDR_WBUF_CTRL, '0);
    expect_reg(spim_pkg::ADDR_DIAG1, '0, 32'hff, "wbuf level flushed");
    report_test("wbuf_overflow", e0);
  endtask

  task automatic test_rbuf_underflow();
    int e0;
    e0 = errors;
    expect_reg(spim_pkg::ADDR_RXDATA, '0, '1, "empty rxdata");
    expect_reg(spim_pkg::ADDR_RBUF_STAT, 32'd1 << spim_pkg::STAT_UDF, '1, "rbuf udf");
    apb_write(spim_pkg::ADDR_RBUF_CTRL, 32'd1 << spim_pkg::CTRL_CLR_UDF);
    apb_write(spim_pkg::ADDR_RBUF_CTRL, '0);
    expect_reg(spim_pkg::ADDR_RBUF_STAT, '0, '1, "rbuf udf cleared");
    report_test("rbuf_underflow", e0);
  endtask

  task automatic test_stall();
    int              e0;
    spim_pkg::word_t w0;
    spim_pkg::word_t w1;
    e0 = errors;
    w0 = rand_word();
    w1 = rand_word();
    apb_write(spim_pkg::ADDR_TXDATA, w0);
    apb_write(spim_pkg::ADDR_CMD, {2'b01, 14'b0, 8'd2, 8'h01});
    // engine parks on empty wbuf after the first word
    repeat (400) @(posedge aclk);
    @(negedge aclk);
    check_bit(sclk, 1'b0, "sclk while stalled");
    expect_reg(spim_pkg::ADDR_STATUS, 32'd1, '1, "busy while stalled");
    expect_reg(spim_pkg::ADDR_DIAG1, 32'd1 << 8, 32'hff00, "rbuf level stalled");
    apb_write(spim_pkg::ADDR_TXDATA, w1);
    wait_busy(1'b0);
    expect_reg(spim_pkg::ADDR_RXDATA, w0, '1, "rxdata first");
    expect_reg(spim_pkg::ADDR_RXDATA, w1, '1, "rxdata second");
    report_test("stall", e0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    aclk      = 1'b0;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    rng_state = 32'hd7fb_fa3c;
    repeat (16) @(posedge aclk);
    arst_n <= 1'b1;
    test_reset_decode();
    test_cmd_mask();
    test_loopback();
    test_wbuf_overflow();
    test_rbuf_underflow();
    test_stall();
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/spim_pkg.sv
verilog/spim_buf_if.sv
verilog/spim_fifo.sv
verilog/spim_csr.sv
verilog/spim_engine.sv
verilog/spim_top.sv
tb/spim_tb.sv

//--- Bender.yml
package:
  name: spim

sources:
  - verilog/spim_pkg.sv
  - verilog/spim_buf_if.sv
  - verilog/spim_fifo.sv
  - verilog/spim_csr.sv
  - verilog/spim_engine.sv
  - verilog/spim_top.sv
  - target: test
    files:
      - tb/spim_tb.sv
